// ==== Bender.yml ====
package:
  name: quant_neuron

sources:
  - qnnPkg.sv
  - quantCfgRegs.sv
  - macAccumulator.sv
  - outputScaler.sv
  - quantNeuron.sv
  - target: test
    files:
      - tbQuantNeuron.sv

// ==== macAccumulator.sv ====
// Signed multiply-accumulate over one vector of activation/weight pairs.
// One pair per inValid cycle; inLast marks the final pair. One cycle after
// that pair, accSum holds the vector sum and accDone pulses. A new vector can
// start on the very next cycle. The sum wraps at inputWidth bits.
`timescale 1ns/1ns
`default_nettype none

module macAccumulator #(
    parameter int inputWidth = qnnPkg::defaultInputWidth
) (
    input  wire logic                                 clk,
    input  wire logic                                 arstN,
    input  wire logic                                 inValid,
    input  wire logic                                 inLast,
    input  wire logic signed [qnnPkg::operandWidth-1:0] actIn,
    input  wire logic signed [qnnPkg::operandWidth-1:0] wgtIn,
    output logic      signed [inputWidth-1:0]         accSum,
    output logic                                      accDone
);

    import qnnPkg::*;

    // Full signed product width of one pair
    localparam int productWidth = 2 * operandWidth;

    accStateT                       state;
    logic signed [productWidth-1:0] product;
    logic signed [inputWidth-1:0]   productExt;
    logic signed [inputWidth-1:0]   runSum;
    logic signed [inputWidth-1:0]   nextSum;

    // Both operands signed, so a plain signed multiply
    assign product = actIn * wgtIn;

    // Sign-extend the product up to the accumulator width
    assign productExt = {{(inputWidth - productWidth){product[productWidth-1]}}, product};

    // First pair of a vector replaces the sum, later pairs add to it
    // Addition wraps naturally at inputWidth bits
    assign nextSum = (state == accIdle) ? productExt : runSum + productExt;

    // Control state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= accIdle;
            accDone <= 1'b0;
        end else begin
            accDone <= inValid && inLast;
            if (inValid) begin
                // Last pair closes the vector, anything else keeps it open
                state <= inLast ? accIdle : accRun;
            end
        end
    end

    // Running and completed sums
    always_ff @(posedge clk) begin
        if (inValid) begin
            runSum <= nextSum;
            if (inLast) begin
                accSum <= nextSum;
            end
        end
    end

    // inLast only counts together with a pair
    lastNeedsValid: assert property (
        @(posedge clk) disable iff (!arstN)
        inLast |-> inValid
    ) else $error("inLast without inValid");

    // Two done pulses in a row mean the second vector was a single pair
    // arriving right behind the last pair of the previous vector
    doneBackToBack: assert property (
        @(posedge clk) disable iff (!arstN)
        (accDone && $past(accDone)) |->
            $past(inValid && inLast, 1) && $past(inValid && inLast, 2) &&
            ($past(state, 1) == accIdle)
    ) else $error("accDone twice in a row without single-pair vectors");

endmodule

`default_nettype wire

// ==== outputScaler.sv ====
// Requantizing output scaler for one accumulated sum.
// sum * scale / 2^fixedPointBits, then an arithmetic right shift by shift,
// then a clip to a signed or unsigned range of outBits bits. Both shifts
// round toward minus infinity. The result is registered: outData updates
// and outValid pulses one cycle after accDone.
`timescale 1ns/1ns
`default_nettype none

module outputScaler #(
    parameter int inputWidth     = qnnPkg::defaultInputWidth,
    parameter int maxOutputWidth = qnnPkg::defaultMaxOutputWidth,
    parameter int fixedPointBits = qnnPkg::defaultFixedPointBits,
    parameter int shiftBits      = qnnPkg::defaultShiftBits
) (
    input  wire logic                                 clk,
    input  wire logic                                 arstN,
    input  wire logic signed [inputWidth-1:0]         accSum,
    input  wire logic                                 accDone,
    input  wire logic        [fixedPointBits-1:0]     scale,
    input  wire logic        [shiftBits-1:0]          shift,
    input  wire logic                                 isUnsigned,
    input  wire logic [$clog2(maxOutputWidth+1)-1:0]  outBits,
    output logic             [maxOutputWidth-1:0]     outData,
    output logic                                      outValid
);

    // Magnitude below 2^(inputWidth-1) times scale below 2^fixedPointBits
    // always fits in this many bits as a signed value
    localparam int productWidth = inputWidth + fixedPointBits;

    logic                            sumNeg;
    logic        [inputWidth-1:0]    sumMag;
    logic        [productWidth-1:0]  magProduct;
    logic signed [productWidth-1:0]  scaledSum;
    logic signed [productWidth-1:0]  fracDropped;
    logic signed [productWidth-1:0]  shifted;
    logic signed [productWidth-1:0]  limitHigh;
    logic signed [productWidth-1:0]  limitLow;
    logic        [maxOutputWidth-1:0] clipped;

    // Unsigned multiply on the magnitude avoids mixed-sign multiply rules
    always_comb begin
        sumNeg = accSum[inputWidth-1];
        // -(-2^(n-1)) still reads correctly as an unsigned magnitude
        sumMag = sumNeg ? -accSum : accSum;
        magProduct = productWidth'(sumMag) * productWidth'(scale);
        // Put the sign back
        scaledSum = sumNeg ? -$signed(magProduct) : $signed(magProduct);
    end

    // Drop the fraction, then apply the configured shift
    // Arithmetic shifts floor toward minus infinity for negative values
    always_comb begin
        fracDropped = scaledSum >>> fixedPointBits;
        shifted     = fracDropped >>> shift;
    end

    // Clip limits for the configured width and mode
    always_comb begin
        if (isUnsigned) begin
            // 0 .. 2^outBits - 1
            limitHigh = (productWidth'(1) << outBits) - 1;
            limitLow  = '0;
        end else begin
            // -2^(outBits-1) .. 2^(outBits-1) - 1
            limitHigh = (productWidth'(1) << (outBits - 1)) - 1;
            limitLow  = -$signed(productWidth'(1) << (outBits - 1));
        end
    end

    // Saturating clip, all compares signed at full product width
    always_comb begin
        if (shifted > limitHigh) begin
            clipped = limitHigh[maxOutputWidth-1:0];
        end else if (shifted < limitLow) begin
            clipped = limitLow[maxOutputWidth-1:0];
        end else begin
            clipped = shifted[maxOutputWidth-1:0];
        end
    end

    // Output register, loaded only when a new sum arrives
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outData  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= accDone;
            if (accDone) begin
                outData <= clipped;
            end
        end
    end

    // Every result fits the mode and width that were live in the accDone cycle
    // Unsigned results have no bits above outBits, signed ones are sign-extended
    resultInRange: assert property (
        @(posedge clk) disable iff (!arstN)
        outValid |-> ($past(isUnsigned)
            ? ((outData >> $past(outBits)) == 0)
            : ((($signed(outData) >>> ($past(outBits) - 1)) == 0) ||
               (($signed(outData) >>> ($past(outBits) - 1)) == -1)))
    ) else $error("outData 0x%0h outside the configured range", outData);

endmodule

`default_nettype wire

// ==== qnnPkg.sv ====
// Shared widths and state encoding for the requantizing neuron output stage.
// Modules take the defaults as qnnPkg::name in their parameter lists and
// import the package in the body where they need the rest.
`default_nettype none

package qnnPkg;

    // Activation and weight width, both signed
    localparam int operandWidth = 8;

    // Accumulator and vector sum width
    // Holds about 32 full-scale products before it wraps
    localparam int defaultInputWidth = 20;

    // Widest clipped result, in bits
    localparam int defaultMaxOutputWidth = 8;

    // Fraction bits of the unsigned fixed-point scale
    localparam int defaultFixedPointBits = 16;

    // Width of the extra arithmetic right shift
    localparam int defaultShiftBits = 5;

    // Accumulator state
    // accIdle means the next product starts a new vector
    // accRun means the next product adds to the running sum
    typedef enum logic {
        accIdle,
        accRun
    } accStateT;

endpackage

`default_nettype wire

// ==== quantCfgRegs.sv ====
// Requantization configuration registers.
// A one-cycle cfgLoad captures scale, shift, signed/unsigned mode and output
// width. The new values reach the scaler on the following cycle. Change the
// configuration only between vectors.
`timescale 1ns/1ns
`default_nettype none

module quantCfgRegs #(
    parameter int fixedPointBits = qnnPkg::defaultFixedPointBits,
    parameter int shiftBits      = qnnPkg::defaultShiftBits,
    parameter int maxOutputWidth = qnnPkg::defaultMaxOutputWidth
) (
    input  wire logic                                 clk,
    input  wire logic                                 arstN,
    input  wire logic                                 cfgLoad,
    input  wire logic [fixedPointBits-1:0]            cfgScale,
    input  wire logic [shiftBits-1:0]                 cfgShift,
    input  wire logic                                 cfgUnsigned,
    input  wire logic [$clog2(maxOutputWidth+1)-1:0]  cfgOutBits,
    output logic      [fixedPointBits-1:0]            scale,
    output logic      [shiftBits-1:0]                 shift,
    output logic                                      isUnsigned,
    output logic      [$clog2(maxOutputWidth+1)-1:0]  outBits
);

    // Width of the output-bits field, same as the port above
    localparam int outBitsWidth = $clog2(maxOutputWidth + 1);

    // Reset gives scale 0, shift 0, signed mode, full output width
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scale      <= '0;
            shift      <= '0;
            isUnsigned <= 1'b0;
            outBits    <= outBitsWidth'(maxOutputWidth);
        end else if (cfgLoad) begin
            scale      <= cfgScale;
            shift      <= cfgShift;
            isUnsigned <= cfgUnsigned;
            outBits    <= cfgOutBits;
        end
    end

    // Output width must stay within 1..maxOutputWidth
    // A zero width would make the clip limits meaningless in the scaler
    cfgOutBitsRange: assert property (
        @(posedge clk) disable iff (!arstN)
        cfgLoad |-> (cfgOutBits != '0) && (cfgOutBits <= maxOutputWidth)
    ) else $error("cfgOutBits %0d out of range on load", cfgOutBits);

endmodule

`default_nettype wire

// ==== quantNeuron.f ====
qnnPkg.sv
quantCfgRegs.sv
macAccumulator.sv
outputScaler.sv
quantNeuron.sv
tbQuantNeuron.sv

// ==== quantNeuron.sv ====
// Top level of the requantizing neuron output stage.
// Config registers, multiply-accumulate and output scaler in a chain.
// outValid follows the inValid-with-inLast cycle by exactly two cycles.
// Results are pulses with no back-pressure.
`timescale 1ns/1ns
`default_nettype none

module quantNeuron #(
    parameter int inputWidth     = qnnPkg::defaultInputWidth,
    parameter int maxOutputWidth = qnnPkg::defaultMaxOutputWidth,
    parameter int fixedPointBits = qnnPkg::defaultFixedPointBits,
    parameter int shiftBits      = qnnPkg::defaultShiftBits
) (
    input  wire logic                                   clk,
    input  wire logic                                   arstN,
    // Configuration load
    input  wire logic                                   cfgLoad,
    input  wire logic        [fixedPointBits-1:0]       cfgScale,
    input  wire logic        [shiftBits-1:0]            cfgShift,
    input  wire logic                                   cfgUnsigned,
    input  wire logic [$clog2(maxOutputWidth+1)-1:0]    cfgOutBits,
    // Operand stream
    input  wire logic                                   inValid,
    input  wire logic                                   inLast,
    input  wire logic signed [qnnPkg::operandWidth-1:0] actIn,
    input  wire logic signed [qnnPkg::operandWidth-1:0] wgtIn,
    // Result
    output logic                                        outValid,
    output logic             [maxOutputWidth-1:0]       outData
);

    // Live configuration
    logic        [fixedPointBits-1:0]            scale;
    logic        [shiftBits-1:0]                 shift;
    logic                                        isUnsigned;
    logic        [$clog2(maxOutputWidth+1)-1:0]  outBits;

    // Completed vector sum
    logic signed [inputWidth-1:0]                accSum;
    logic                                        accDone;

    quantCfgRegs #(
        .fixedPointBits(fixedPointBits),
        .shiftBits     (shiftBits),
        .maxOutputWidth(maxOutputWidth)
    ) i_cfgRegs (
        .clk        (clk),
        .arstN      (arstN),
        .cfgLoad    (cfgLoad),
        .cfgScale   (cfgScale),
        .cfgShift   (cfgShift),
        .cfgUnsigned(cfgUnsigned),
        .cfgOutBits (cfgOutBits),
        .scale      (scale),
        .shift      (shift),
        .isUnsigned (isUnsigned),
        .outBits    (outBits)
    );

    macAccumulator #(
        .inputWidth(inputWidth)
    ) i_mac (
        .clk    (clk),
        .arstN  (arstN),
        .inValid(inValid),
        .inLast (inLast),
        .actIn  (actIn),
        .wgtIn  (wgtIn),
        .accSum (accSum),
        .accDone(accDone)
    );

    // Scaler samples the config in the accDone cycle
    outputScaler #(
        .inputWidth    (inputWidth),
        .maxOutputWidth(maxOutputWidth),
        .fixedPointBits(fixedPointBits),
        .shiftBits     (shiftBits)
    ) i_scaler (
        .clk       (clk),
        .arstN     (arstN),
        .accSum    (accSum),
        .accDone   (accDone),
        .scale     (scale),
        .shift     (shift),
        .isUnsigned(isUnsigned),
        .outBits   (outBits),
        .outData   (outData),
        .outValid  (outValid)
    );

endmodule

`default_nettype wire

// ==== quantNeuronTrace.txt ====
# Records: T name gapMode | C scaleHex shift unsigned outBits | P act wgt last | E expected
# E follows the last pair of a vector and gives outData in decimal
T signedHalf 1
C 8000 0 0 8
P 3 5 0
P 2 -4 1
E 3
P -3 3 1
E -5
P 10 10 0
P -1 1 0
P 4 -2 1
E 45
T signedSat 1
C ffff 0 0 8
P 127 127 0
P 100 100 1
E 127
P -128 127 1
E -128
C ffff 0 0 4
P 5 2 1
E 7
P -3 3 1
E -8
P 2 3 1
E 5
T unsignedMode 1
C 8000 0 1 8
P -10 10 1
E 0
P 100 100 0
P 50 20 1
E 255
C 8000 0 1 4
P 20 10 1
E 15
P 3 3 1
E 4
P -1 1 1
E 0
T shiftRound 1
C ffff 1 0 8
P -5 1 1
E -3
C 8000 2 0 8
P -5 1 1
E -1
P 13 1 1
E 1
C ffff 4 0 8
P 40 8 1
E 19
T backToBack 0
C 8000 0 0 8
P 4 4 1
E 8
P -6 2 1
E -6
P 3 3 0
P 1 1 1
E 5
P 7 7 1
E 24
P -1 1 1
E -1
P 2 2 0
P 2 2 0
P 2 2 1
E 6

// ==== tbQuantNeuron.sv ====
// Trace-driven testbench for the requantizing neuron output stage.
// Replays config loads, operand pairs and expected results from
// quantNeuronTrace.txt in the project root. A falling-edge monitor checks
// every outValid pulse against the queued expectation, both its value and
// the cycle it arrives in.
`timescale 1ns/1ns
`default_nettype none

module tbQuantNeuron;

    import qnnPkg::*;

    localparam int clkHalf       = 20;
    localparam int driveDelay    = 2;
    localparam int pipeLatency   = 2;
    localparam int resultTimeout = 20;
    localparam int outBitsWidth  = $clog2(defaultMaxOutputWidth + 1);

    logic                               clk;
    logic                               arstN;
    logic                               cfgLoad;
    logic        [defaultFixedPointBits-1:0] cfgScale;
    logic        [defaultShiftBits-1:0] cfgShift;
    logic                               cfgUnsigned;
    logic        [outBitsWidth-1:0]     cfgOutBits;
    logic                               inValid;
    logic                               inLast;
    logic signed [operandWidth-1:0]     actIn;
    logic signed [operandWidth-1:0]     wgtIn;
    logic                               outValid;
    logic        [defaultMaxOutputWidth-1:0] outData;

    // Expected results in arrival order, each with the cycle it is due
    logic [defaultMaxOutputWidth-1:0] expQ[$];
    int                               dueQ[$];

    int cycleCount  = 0;
    int lastDue     = 0;
    int testErrors  = 0;
    int testResults = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    quantNeuron i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .cfgLoad    (cfgLoad),
        .cfgScale   (cfgScale),
        .cfgShift   (cfgShift),
        .cfgUnsigned(cfgUnsigned),
        .cfgOutBits (cfgOutBits),
        .inValid    (inValid),
        .inLast     (inLast),
        .actIn      (actIn),
        .wgtIn      (wgtIn),
        .outValid   (outValid),
        .outData    (outData)
    );

    // 40 ns clock
    initial clk = 1'b0;
    always #clkHalf clk = ~clk;

    // Cycle number, read at the falling edge and after the drive delay
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Result monitor, samples away from the rising edge
    always @(negedge clk) begin : resultMonitor
        logic [defaultMaxOutputWidth-1:0] expData;
        int                               expDue;
        if (arstN && outValid) begin
            assert (expQ.size() > 0) else begin
                $display("Error at %0t: outValid pulse with no vector pending", $time);
                testErrors++;
            end
            if (expQ.size() > 0) begin
                expData = expQ.pop_front();
                expDue  = dueQ.pop_front();
                testResults++;
                // Arrival must be exactly two cycles after the last pair
                assert (cycleCount == expDue) else begin
                    $display("Mismatch at %0t: outValid cycle expected %0d, got %0d",
                             $time, expDue, cycleCount);
                    testErrors++;
                end
                assert (outData === expData) else begin
                    $display("Mismatch at %0t: outData expected 0x%02h, got 0x%02h",
                             $time, expData, outData);
                    testErrors++;
                end
            end
        end
    end

    // One clock, then the drive delay
    task automatic stepCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic loadConfig(input int scaleVal, input int shiftVal,
                              input int unsVal, input int bitsVal);
        cfgScale    = defaultFixedPointBits'(scaleVal);
        cfgShift    = defaultShiftBits'(shiftVal);
        cfgUnsigned = (unsVal != 0);
        cfgOutBits  = outBitsWidth'(bitsVal);
        cfgLoad     = 1'b1;
        stepCycle();
        cfgLoad     = 1'b0;
    endtask

    task automatic drivePair(input int act, input int wgt, input int last);
        actIn   = operandWidth'(act);
        wgtIn   = operandWidth'(wgt);
        inValid = 1'b1;
        inLast  = (last != 0);
        // Result due two cycles after the cycle that carries the last pair
        if (last != 0) begin
            lastDue = cycleCount + pipeLatency;
        end
        stepCycle();
        inValid = 1'b0;
        inLast  = 1'b0;
    endtask

    // Random idle time between vectors, 0 to 2 cycles
    task automatic idleGap();
        int gap;
        gap = $urandom % 3;
        repeat (gap) begin
            stepCycle();
        end
    endtask

    // Bounded wait until every queued result has come out
    task automatic drainResults();
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < resultTimeout) begin
            stepCycle();
            waited++;
        end
        assert (expQ.size() == 0) else begin
            $display("Error at %0t: %0d results did not arrive within %0d cycles",
                     $time, expQ.size(), resultTimeout);
            testErrors++;
            expQ.delete();
            dueQ.delete();
        end
    endtask

    task automatic finishTest(input logic [8*24-1:0] name);
        if (testErrors == 0) begin
            testsPassed++;
            $display("Test %0s: ok, %0d results checked", name, testResults);
        end else begin
            testsFailed++;
            $display("Test %0s: %0d errors, %0d results checked", name, testErrors, testResults);
        end
        testErrors  = 0;
        testResults = 0;
    endtask

    // Quiet outputs right after reset, before any input
    task automatic checkResetIdle();
        repeat (4) begin
            @(negedge clk);
            assert (outValid === 1'b0) else begin
                $display("Mismatch at %0t: outValid expected 0, got %b", $time, outValid);
                testErrors++;
            end
            assert (outData === '0) else begin
                $display("Mismatch at %0t: outData expected 0x00, got 0x%02h", $time, outData);
                testErrors++;
            end
        end
        stepCycle();
    endtask

    initial begin : mainSequence
        int               fd;
        int               code;
        int               gapMode;
        int               testOpen;
        int               aVal;
        int               bVal;
        int               cVal;
        int               dVal;
        logic [8*16-1:0]  tok;
        logic [8*24-1:0]  name;
        logic [8*24-1:0]  curName;
        logic [8*128-1:0] lineBuf;

        code = $urandom(32'h4675);
        arstN       = 1'b0;
        cfgLoad     = 1'b0;
        cfgScale    = '0;
        cfgShift    = '0;
        cfgUnsigned = 1'b0;
        cfgOutBits  = outBitsWidth'(defaultMaxOutputWidth);
        inValid     = 1'b0;
        inLast      = 1'b0;
        actIn       = '0;
        wgtIn       = '0;
        gapMode     = 0;
        testOpen    = 0;
        curName     = '0;

        // Two cycles of reset
        repeat (2) begin
            @(posedge clk);
        end
        #driveDelay;
        arstN = 1'b1;

        checkResetIdle();
        finishTest("resetIdle");

        fd = $fopen("quantNeuronTrace.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open quantNeuronTrace.txt");
            testsFailed++;
        end else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(lineBuf, fd);
                end else if (tok == "T") begin
                    // New test closes the previous one
                    code = $fscanf(fd, "%s %d", name, gapMode);
                    if (testOpen != 0) begin
                        drainResults();
                        finishTest(curName);
                    end
                    curName  = name;
                    testOpen = 1;
                end else if (tok == "C") begin
                    code = $fscanf(fd, "%h %d %d %d", aVal, bVal, cVal, dVal);
                    loadConfig(aVal, bVal, cVal, dVal);
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%d %d %d", aVal, bVal, cVal);
                    drivePair(aVal, bVal, cVal);
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%d", aVal);
                    expQ.push_back(aVal[defaultMaxOutputWidth-1:0]);
                    dueQ.push_back(lastDue);
                    if (gapMode != 0) begin
                        idleGap();
                    end
                end else begin
                    $display("Error: unknown trace record %0s", tok);
                    testErrors++;
                    code = $fgets(lineBuf, fd);
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            if (testOpen != 0) begin
                drainResults();
                finishTest(curName);
            end
        end

        $display("Summary: %0d tests passed, %0d tests failed", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
